// File: src/arc_pkg.sv
`default_nettype none

package arc_pkg;

	// bus and loader widths
	localparam int LOADER_ADDR_W = 24;
	localparam int RAM_ADDR_W    = 26;
	localparam int DATA_W        = 32;
	localparam int SEL_W         = 4;

	typedef logic [DATA_W-1:0]        word_t;
	typedef logic [SEL_W-1:0]         sel_t;
	typedef logic [LOADER_ADDR_W-1:0] loader_addr_t;

	// word aligned, top two bits always zero
	typedef logic [RAM_ADDR_W-1:0]    ram_addr_t;

	typedef logic [7:0]               index_t;

	// download index as seen from the loader
	typedef enum index_t {
		IDX_CORE_ROM = 8'd1,
		IDX_EXT_ROM  = 8'd2,
		IDX_CMOS     = 8'd3
	} loader_index_e;

	// who holds the RAM bus
	typedef enum logic [1:0] {
		OWNER_IDLE   = 2'd0,
		OWNER_LOADER = 2'd1,
		OWNER_CORE   = 2'd2
	} bus_owner_e;

endpackage

`default_nettype wire

// File: src/loader_if.sv
`timescale 1ns/100ps
`default_nettype none

// capture stage into the word queue
interface loader_push_if;

	logic                  push;
	arc_pkg::loader_addr_t addr;
	arc_pkg::sel_t         sel;
	arc_pkg::word_t        data;

	modport producer (
		output push,
		output addr,
		output sel,
		output data
	);

	modport sink (
		input push,
		input addr,
		input sel,
		input data
	);

endinterface

// oldest queued word, offered to the arbiter
interface loader_head_if;

	logic               valid;
	arc_pkg::ram_addr_t addr;
	arc_pkg::sel_t      sel;
	arc_pkg::word_t     data;
	logic               pop;

	modport source (
		output valid,
		output addr,
		output sel,
		output data,
		input  pop
	);

	modport drain (
		input  valid,
		input  addr,
		input  sel,
		input  data,
		output pop
	);

endinterface

`default_nettype wire

// File: src/loader_capture.sv
`timescale 1ns/100ps
`default_nettype none

module loader_capture (
	input  wire                          clk_sys,
	input  wire                          rst_n_i,
	input  wire                          downloading_i,
	input  wire arc_pkg::index_t         index_i,
	input  wire                          loader_we_i,
	input  wire arc_pkg::loader_addr_t   loader_addr_i,
	input  wire arc_pkg::sel_t           loader_sel_i,
	input  wire arc_pkg::word_t          loader_dat_i,
	input  wire                          ram_ready_i,
	input  wire                          reset_button_i,
	loader_push_if.producer              push,
	output logic                         loader_active_o,
	output logic                         rom_ready_o,
	output logic                         core_reset_o
);

	logic rom_index;
	logic active_q;
	logic take;

	// only the two ROM images go to RAM
	always_comb begin
		case (arc_pkg::loader_index_e'(index_i))
			arc_pkg::IDX_CORE_ROM,
			arc_pkg::IDX_EXT_ROM: rom_index = 1'b1;
			default:              rom_index = 1'b0;
		endcase
	end

	assign loader_active_o = downloading_i && rom_index;
	assign take            = loader_we_i && loader_active_o;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			active_q     <= 1'b0;
			rom_ready_o  <= 1'b0;
			core_reset_o <= 1'b1;
			push.push    <= 1'b0;
		end else begin
			active_q  <= loader_active_o;
			push.push <= take;
			// end of loader activity marks a complete ROM
			if (active_q && !loader_active_o) begin
				rom_ready_o <= 1'b1;
			end
			core_reset_o <= !rom_ready_o || !ram_ready_i || reset_button_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			push.addr <= loader_addr_i;
			push.sel  <= loader_sel_i;
			push.data <= loader_dat_i;
		end
	end

endmodule

`default_nettype wire

// File: src/loader_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module loader_fifo #(
	parameter int DEPTH = 4
) (
	input  wire          clk_sys,
	input  wire          rst_n_i,
	loader_push_if.sink  push,
	loader_head_if.source head,
	output logic         overflow_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// queued payload
	arc_pkg::ram_addr_t addr_mem [DEPTH];
	arc_pkg::sel_t      sel_mem  [DEPTH];
	arc_pkg::word_t     data_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(DEPTH));
	assign do_push = push.push && !full;
	assign do_pop  = head.pop && (count != '0);

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			// byte address from loader becomes a word aligned RAM address
			addr_mem[wr_ptr] <= {2'b00, push.addr[arc_pkg::LOADER_ADDR_W-1:2], 2'b00};
			sel_mem[wr_ptr]  <= push.sel;
			data_mem[wr_ptr] <= push.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// sticky until reset
			if (push.push && full) begin
				overflow_o <= 1'b1;
			end
		end
	end

	assign head.valid = (count != '0);
	assign head.addr  = addr_mem[rd_ptr];
	assign head.sel   = sel_mem[rd_ptr];
	assign head.data  = data_mem[rd_ptr];

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
	input  wire                       clk_sys,
	input  wire                       rst_n_i,
	input  wire                       loader_active_i,
	loader_head_if.drain              head,
	input  wire                       core_stb_i,
	input  wire                       core_we_i,
	input  wire arc_pkg::sel_t        core_sel_i,
	input  wire arc_pkg::ram_addr_t   core_adr_i,
	input  wire arc_pkg::word_t       core_dat_i,
	output logic                      core_ack_o,
	output arc_pkg::word_t            core_dat_o,
	output logic                      ram_stb_o,
	output logic                      ram_cyc_o,
	output logic                      ram_we_o,
	output arc_pkg::sel_t             ram_sel_o,
	output arc_pkg::ram_addr_t        ram_adr_o,
	output arc_pkg::word_t            ram_dat_o,
	input  wire                       ram_ack_i,
	input  wire arc_pkg::word_t       ram_dat_i
);

	arc_pkg::bus_owner_e owner;
	arc_pkg::ram_addr_t  core_adr_aligned;
	logic                loader_req;
	logic                core_req;

	assign core_adr_aligned = {2'b00, core_adr_i[arc_pkg::RAM_ADDR_W-3:2], 2'b00};

	// loader has priority, core waits while loading runs
	assign loader_req = head.valid;
	assign core_req   = core_stb_i && !loader_active_i && !head.valid;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			owner     <= arc_pkg::OWNER_IDLE;
			ram_stb_o <= 1'b0;
			ram_cyc_o <= 1'b0;
		end else begin
			case (owner)
				arc_pkg::OWNER_IDLE: begin
					if (loader_req) begin
						owner     <= arc_pkg::OWNER_LOADER;
						ram_stb_o <= 1'b1;
						ram_cyc_o <= 1'b1;
					end else if (core_req) begin
						owner     <= arc_pkg::OWNER_CORE;
						ram_stb_o <= 1'b1;
						ram_cyc_o <= 1'b1;
					end
				end
				arc_pkg::OWNER_LOADER, arc_pkg::OWNER_CORE: begin
					// one transfer per grant, back to idle on ack
					if (ram_ack_i) begin
						owner     <= arc_pkg::OWNER_IDLE;
						ram_stb_o <= 1'b0;
						ram_cyc_o <= 1'b0;
					end
				end
				default: owner <= arc_pkg::OWNER_IDLE;
			endcase
		end
	end

	// bus payload follows the requester while idle, frozen while owned
	always_ff @(posedge clk_sys) begin
		if (owner == arc_pkg::OWNER_IDLE) begin
			if (loader_req) begin
				ram_we_o  <= 1'b1;
				ram_sel_o <= head.sel;
				ram_adr_o <= head.addr;
				ram_dat_o <= head.data;
			end else begin
				ram_we_o  <= core_we_i;
				ram_sel_o <= core_sel_i;
				ram_adr_o <= core_adr_aligned;
				ram_dat_o <= core_dat_i;
			end
		end
	end

	assign head.pop   = (owner == arc_pkg::OWNER_LOADER) && ram_ack_i;
	assign core_ack_o = (owner == arc_pkg::OWNER_CORE) && ram_ack_i;
	assign core_dat_o = ram_dat_i;

endmodule

`default_nettype wire

// File: src/clken_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clken_gen #(
	parameter int PERIOD = 20
) (
	input  wire  clk_sys,
	input  wire  rst_n_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);

	localparam int QUARTER = PERIOD / 4;
	localparam int CNT_W   = $clog2(PERIOD);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			count      <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			if (count == CNT_W'(PERIOD - 1)) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
			clk2m_en_o <= (count == '0);
			// four evenly spaced strobes per period
			clk8m_en_o <= (count == '0) ||
				(count == CNT_W'(QUARTER)) ||
				(count == CNT_W'(2 * QUARTER)) ||
				(count == CNT_W'(3 * QUARTER));
		end
	end

endmodule

`default_nettype wire

// File: src/arc_loader_top.sv
`timescale 1ns/100ps
`default_nettype none

module arc_loader_top #(
	parameter int LOADER_FIFO_DEPTH = 4,
	parameter int CLKEN_PERIOD      = 20
) (
	input  wire                          clk_sys,
	input  wire                          rst_n_i,
	input  wire                          downloading_i,
	input  wire arc_pkg::index_t         index_i,
	input  wire                          loader_we_i,
	input  wire arc_pkg::loader_addr_t   loader_addr_i,
	input  wire arc_pkg::sel_t           loader_sel_i,
	input  wire arc_pkg::word_t          loader_dat_i,
	input  wire                          ram_ready_i,
	input  wire                          reset_button_i,
	input  wire                          core_stb_i,
	input  wire                          core_we_i,
	input  wire arc_pkg::sel_t           core_sel_i,
	input  wire arc_pkg::ram_addr_t      core_adr_i,
	input  wire arc_pkg::word_t          core_dat_i,
	output logic                         core_ack_o,
	output arc_pkg::word_t               core_dat_o,
	output logic                         ram_stb_o,
	output logic                         ram_cyc_o,
	output logic                         ram_we_o,
	output arc_pkg::sel_t                ram_sel_o,
	output arc_pkg::ram_addr_t           ram_adr_o,
	output arc_pkg::word_t               ram_dat_o,
	input  wire                          ram_ack_i,
	input  wire arc_pkg::word_t          ram_dat_i,
	output logic                         overflow_o,
	output logic                         rom_ready_o,
	output logic                         core_reset_o,
	output logic                         clk2m_en_o,
	output logic                         clk8m_en_o
);

	logic loader_active;

	loader_push_if push_bus ();
	loader_head_if head_bus ();

	loader_capture u_capture (
		.clk_sys         (clk_sys),
		.rst_n_i         (rst_n_i),
		.downloading_i   (downloading_i),
		.index_i         (index_i),
		.loader_we_i     (loader_we_i),
		.loader_addr_i   (loader_addr_i),
		.loader_sel_i    (loader_sel_i),
		.loader_dat_i    (loader_dat_i),
		.ram_ready_i     (ram_ready_i),
		.reset_button_i  (reset_button_i),
		.push            (push_bus.producer),
		.loader_active_o (loader_active),
		.rom_ready_o     (rom_ready_o),
		.core_reset_o    (core_reset_o)
	);

	loader_fifo #(
		.DEPTH (LOADER_FIFO_DEPTH)
	) u_fifo (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.push       (push_bus.sink),
		.head       (head_bus.source),
		.overflow_o (overflow_o)
	);

	mem_arbiter u_arbiter (
		.clk_sys         (clk_sys),
		.rst_n_i         (rst_n_i),
		.loader_active_i (loader_active),
		.head            (head_bus.drain),
		.core_stb_i      (core_stb_i),
		.core_we_i       (core_we_i),
		.core_sel_i      (core_sel_i),
		.core_adr_i      (core_adr_i),
		.core_dat_i      (core_dat_i),
		.core_ack_o      (core_ack_o),
		.core_dat_o      (core_dat_o),
		.ram_stb_o       (ram_stb_o),
		.ram_cyc_o       (ram_cyc_o),
		.ram_we_o        (ram_we_o),
		.ram_sel_o       (ram_sel_o),
		.ram_adr_o       (ram_adr_o),
		.ram_dat_o       (ram_dat_o),
		.ram_ack_i       (ram_ack_i),
		.ram_dat_i       (ram_dat_i)
	);

	clken_gen #(
		.PERIOD (CLKEN_PERIOD)
	) u_clken (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.clk2m_en_o (clk2m_en_o),
		.clk8m_en_o (clk8m_en_o)
	);

endmodule

`default_nettype wire

// File: verification/tb_arc_loader.sv
`timescale 1ns/100ps
`default_nettype none

module tb_arc_loader;

	localparam int FIFO_DEPTH   = 4;
	localparam int CLKEN_PERIOD = 20;
	localparam int N_TESTS      = 6;
	localparam int N_WORDS      = 16;
	localparam int LOAD_GAP     = 8;
	localparam int CYCLE_LIMIT  = N_TESTS * N_WORDS * 10 + 2000;

	logic                  clk_sys = 1'b0;
	logic                  rst_n_i;
	logic                  downloading_i;
	arc_pkg::index_t       index_i;
	logic                  loader_we_i;
	arc_pkg::loader_addr_t loader_addr_i;
	arc_pkg::sel_t         loader_sel_i;
	arc_pkg::word_t        loader_dat_i;
	logic                  ram_ready_i;
	logic                  reset_button_i;
	logic                  core_stb_i;
	logic                  core_we_i;
	arc_pkg::sel_t         core_sel_i;
	arc_pkg::ram_addr_t    core_adr_i;
	arc_pkg::word_t        core_dat_i;
	logic                  core_ack_o;
	arc_pkg::word_t        core_dat_o;
	logic                  ram_stb_o;
	logic                  ram_cyc_o;
	logic                  ram_we_o;
	arc_pkg::sel_t         ram_sel_o;
	arc_pkg::ram_addr_t    ram_adr_o;
	arc_pkg::word_t        ram_dat_o;
	logic                  ram_ack_i;
	arc_pkg::word_t        ram_dat_i;
	logic                  overflow_o;
	logic                  rom_ready_o;
	logic                  core_reset_o;
	logic                  clk2m_en_o;
	logic                  clk8m_en_o;

	// RAM model contents and the reference memory
	arc_pkg::word_t     ram_mem [arc_pkg::ram_addr_t];
	arc_pkg::word_t     exp_mem [arc_pkg::ram_addr_t];
	// loader writes still expected on the bus, in order
	arc_pkg::ram_addr_t exp_adr_q [$];
	arc_pkg::word_t     exp_dat_q [$];
	arc_pkg::word_t     ram_old;
	logic               ram_stall;
	int                 ack_wait     = -1;
	int                 xfer_cnt     = 0;
	int                 xfer_before  = 0;
	int                 cycle_cnt    = 0;
	int                 mismatch_cnt = 0;
	int                 failure_cnt  = 0;
	int                 last_8m      = 0;
	int                 last_2m      = 0;
	int                 pulses_8m    = 0;
	int                 pulses_2m    = 0;
	int                 rnd_seed;

	arc_loader_top #(
		.LOADER_FIFO_DEPTH (FIFO_DEPTH),
		.CLKEN_PERIOD      (CLKEN_PERIOD)
	) uut (.*);

	always #50 clk_sys = ~clk_sys;

	// byte-select merge of a bus word into a stored word
	function automatic arc_pkg::word_t merge_bytes(input arc_pkg::word_t old_w,
		input arc_pkg::word_t new_w, input arc_pkg::sel_t sel);
		arc_pkg::word_t res;
		res = old_w;
		for (int b = 0; b < arc_pkg::SEL_W; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic compare_word(input string name, input arc_pkg::word_t got,
		input arc_pkg::word_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic verify_addr(input string name, input arc_pkg::ram_addr_t got,
		input arc_pkg::ram_addr_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic expect_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic note_failure(input string what);
		failure_cnt++;
		$display("error at cycle %0d: %s", cycle_cnt, what);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// raise the download before the core asks for the bus
	task automatic begin_download(input arc_pkg::index_t idx);
		@(posedge clk_sys);
		downloading_i <= 1'b1;
		index_i       <= idx;
	endtask

	// one download session; only the first keep words are expected in RAM
	task automatic load_words(input arc_pkg::index_t idx, input int n,
		input arc_pkg::loader_addr_t base, input int keep, input int gap);
		arc_pkg::loader_addr_t la;
		arc_pkg::word_t        dat;
		arc_pkg::sel_t         sel;
		arc_pkg::ram_addr_t    ra;
		logic                  loads_ram;
		loads_ram = (idx == arc_pkg::IDX_CORE_ROM) || (idx == arc_pkg::IDX_EXT_ROM);
		@(posedge clk_sys);
		downloading_i <= 1'b1;
		index_i       <= idx;
		for (int i = 0; i < n; i++) begin
			if (gap > 0) begin
				la = base + arc_pkg::loader_addr_t'($urandom_range(63, 0));
			end else begin
				la = base + arc_pkg::loader_addr_t'(4 * i);
			end
			dat = $urandom;
			sel = arc_pkg::sel_t'($urandom_range(15, 1));
			@(posedge clk_sys);
			loader_we_i   <= 1'b1;
			loader_addr_i <= la;
			loader_sel_i  <= sel;
			loader_dat_i  <= dat;
			if (loads_ram && i < keep) begin
				ra = {2'b00, la[arc_pkg::LOADER_ADDR_W-1:2], 2'b00};
				exp_adr_q.push_back(ra);
				exp_dat_q.push_back(dat);
				exp_mem[ra] = merge_bytes(exp_mem.exists(ra) ? exp_mem[ra] : '0, dat, sel);
			end
			if (gap > 0) begin
				@(posedge clk_sys);
				loader_we_i <= 1'b0;
				wait_cycles(gap - 1);
			end
		end
		@(posedge clk_sys);
		loader_we_i <= 1'b0;
		wait_cycles(2);
		downloading_i <= 1'b0;
	endtask

	task automatic core_request(input logic we, input arc_pkg::ram_addr_t adr,
		input arc_pkg::sel_t sel, input arc_pkg::word_t dat);
		@(posedge clk_sys);
		core_stb_i <= 1'b1;
		core_we_i  <= we;
		core_adr_i <= adr;
		core_sel_i <= sel;
		core_dat_i <= dat;
	endtask

	// wait for the core ack, then update or check the reference
	task automatic core_finish();
		arc_pkg::word_t rdat;
		arc_pkg::word_t old_w;
		do begin
			@(negedge clk_sys);
		end while (!core_ack_o);
		rdat  = core_dat_o;
		old_w = exp_mem.exists(core_adr_i) ? exp_mem[core_adr_i] : '0;
		if (core_we_i) begin
			exp_mem[core_adr_i] = merge_bytes(old_w, core_dat_i, core_sel_i);
		end else begin
			compare_word("core_dat_o", rdat, old_w);
		end
		@(posedge clk_sys);
		core_stb_i <= 1'b0;
	endtask

	// RAM model that acks after 1 to 4 cycles unless stalled
	always @(posedge clk_sys) begin
		ram_ack_i <= 1'b0;
		if (!rst_n_i) begin
			ack_wait = -1;
		end else if (ram_stb_o && ram_cyc_o && !ram_ack_i && !ram_stall) begin
			if (ack_wait < 0) begin
				ack_wait = $urandom_range(3, 0);
			end
			if (ack_wait == 0) begin
				ram_ack_i <= 1'b1;
				xfer_cnt++;
				if (ram_we_o) begin
					ram_old = ram_mem.exists(ram_adr_o) ? ram_mem[ram_adr_o] : '0;
					ram_mem[ram_adr_o] = merge_bytes(ram_old, ram_dat_o, ram_sel_o);
					if (exp_adr_q.size() > 0) begin
						verify_addr("ram_adr_o", ram_adr_o, exp_adr_q.pop_front());
						compare_word("ram_dat_o", ram_dat_o, exp_dat_q.pop_front());
					end
				end else begin
					ram_dat_i <= ram_mem.exists(ram_adr_o) ? ram_mem[ram_adr_o] : '0;
				end
			end
			ack_wait--;
		end
	end

	// core back-pressure and clock enable spacing
	always @(negedge clk_sys) begin
		if (rst_n_i) begin
			if (core_ack_o && (downloading_i || exp_adr_q.size() > 0)) begin
				note_failure("core_ack_o rose while loader words were still pending");
			end
			if (ram_cyc_o !== ram_stb_o) begin
				note_failure("ram_cyc_o and ram_stb_o are not at the same level");
			end
			if (clk8m_en_o) begin
				if (pulses_8m > 0 && cycle_cnt - last_8m != CLKEN_PERIOD / 4) begin
					note_failure("clk8m_en_o pulses are not 5 cycles apart");
				end
				last_8m = cycle_cnt;
				pulses_8m++;
			end
			if (clk2m_en_o) begin
				if (!clk8m_en_o) begin
					note_failure("clk2m_en_o pulsed without clk8m_en_o");
				end
				if (pulses_2m > 0 && cycle_cnt - last_2m != CLKEN_PERIOD) begin
					note_failure("clk2m_en_o pulses are not 20 cycles apart");
				end
				last_2m = cycle_cnt;
				pulses_2m++;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		rnd_seed       = $urandom(58);
		rst_n_i        = 1'b0;
		downloading_i  = 1'b0;
		index_i        = '0;
		loader_we_i    = 1'b0;
		loader_addr_i  = '0;
		loader_sel_i   = '0;
		loader_dat_i   = '0;
		ram_ready_i    = 1'b0;
		reset_button_i = 1'b0;
		core_stb_i     = 1'b0;
		core_we_i      = 1'b0;
		core_sel_i     = '0;
		core_adr_i     = '0;
		core_dat_i     = '0;
		ram_ack_i      = 1'b0;
		ram_dat_i      = '0;
		ram_stall      = 1'b0;
		wait_cycles(8);
		rst_n_i <= 1'b1;
		@(negedge clk_sys);
		expect_level("ram_stb_o", ram_stb_o, 1'b0);
		expect_level("ram_cyc_o", ram_cyc_o, 1'b0);
		expect_level("core_ack_o", core_ack_o, 1'b0);
		expect_level("clk2m_en_o", clk2m_en_o, 1'b0);
		expect_level("clk8m_en_o", clk8m_en_o, 1'b0);
		expect_level("rom_ready_o", rom_ready_o, 1'b0);
		expect_level("core_reset_o", core_reset_o, 1'b1);
		expect_level("overflow_o", overflow_o, 1'b0);

		// RAM ready alone does not release the core
		@(posedge clk_sys);
		ram_ready_i <= 1'b1;
		wait_cycles(2);
		@(negedge clk_sys);
		expect_level("core_reset_o", core_reset_o, 1'b1);
		@(posedge clk_sys);
		ram_ready_i <= 1'b0;

		// core ROM download with a core read held pending
		begin_download(arc_pkg::IDX_CORE_ROM);
		core_request(1'b0, 26'h0000008, 4'hf, '0);
		load_words(arc_pkg::IDX_CORE_ROM, N_WORDS, 24'h000000, N_WORDS, LOAD_GAP);
		core_finish();
		wait_cycles(2);
		@(negedge clk_sys);
		expect_level("rom_ready_o", rom_ready_o, 1'b1);
		expect_level("core_reset_o", core_reset_o, 1'b1);
		@(posedge clk_sys);
		ram_ready_i <= 1'b1;
		wait_cycles(2);
		@(negedge clk_sys);
		expect_level("core_reset_o", core_reset_o, 1'b0);

		// extension ROM download, again against a waiting core
		begin_download(arc_pkg::IDX_EXT_ROM);
		core_request(1'b0, 26'h0000104, 4'hf, '0);
		load_words(arc_pkg::IDX_EXT_ROM, N_WORDS, 24'h000100, N_WORDS, LOAD_GAP);
		core_finish();

		// core writes and read-backs across both regions
		for (int i = 0; i < N_WORDS; i++) begin
			core_request(1'b1, {2'b00, 22'($urandom_range(79, 0)), 2'b00},
				arc_pkg::sel_t'($urandom_range(15, 1)), $urandom);
			core_finish();
			core_request(1'b0, core_adr_i, 4'hf, '0);
			core_finish();
		end

		// reset button forces the core back into reset
		@(posedge clk_sys);
		reset_button_i <= 1'b1;
		wait_cycles(2);
		@(negedge clk_sys);
		expect_level("core_reset_o", core_reset_o, 1'b1);
		@(posedge clk_sys);
		reset_button_i <= 1'b0;
		wait_cycles(2);
		@(negedge clk_sys);
		expect_level("core_reset_o", core_reset_o, 1'b0);
		expect_level("rom_ready_o", rom_ready_o, 1'b1);

		// CMOS index writes nothing
		xfer_before = xfer_cnt;
		load_words(arc_pkg::IDX_CMOS, N_WORDS / 2, 24'h000200, 0, LOAD_GAP);
		wait_cycles(10);
		if (xfer_cnt != xfer_before) begin
			note_failure("RAM transfer seen during a CMOS download");
		end

		// stalled RAM and a back-to-back burst overflow the queue
		@(posedge clk_sys);
		ram_stall <= 1'b1;
		load_words(arc_pkg::IDX_EXT_ROM, FIFO_DEPTH + 3, 24'h000300, FIFO_DEPTH, 0);
		@(negedge clk_sys);
		expect_level("overflow_o", overflow_o, 1'b1);
		@(posedge clk_sys);
		ram_stall <= 1'b0;
		while (exp_adr_q.size() > 0) begin
			@(posedge clk_sys);
		end
		wait_cycles(10);

		foreach (exp_mem[a]) begin
			if (!ram_mem.exists(a)) begin
				note_failure($sformatf("no RAM write reached address %h", a));
			end else begin
				compare_word($sformatf("ram[%h]", a), ram_mem[a], exp_mem[a]);
			end
		end
		foreach (ram_mem[a]) begin
			if (!exp_mem.exists(a)) begin
				note_failure($sformatf("unexpected RAM write at address %h", a));
			end
		end
		if (pulses_8m == 0 || pulses_2m == 0) begin
			note_failure("clock enables never pulsed");
		end

		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
		if (mismatch_cnt + failure_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
src/arc_pkg.sv
src/loader_if.sv
src/loader_capture.sv
src/loader_fifo.sv
src/mem_arbiter.sv
src/clken_gen.sv
src/arc_loader_top.sv
verification/tb_arc_loader.sv
